// File: fetch_pkg.sv
package fetch_pkg;

    // byte address as seen by the fetch unit
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // bit 0 marks the lower slot valid, bit 1 the upper
    typedef logic [1:0] slot_mask_t;

    // branch target buffer index, taken from pc bits 6:3
    typedef logic [3:0] btb_idx_t;

    // address bits above the index
    typedef logic [24:0] btb_tag_t;

    // word index into instruction memory
    typedef logic [7:0] mem_addr_t;

    // fetch address after reset
    localparam addr_t pc_reset = 32'h0000_0000;

    // one packet holds two instructions
    localparam int fetch_bytes = 8;

    // direct-mapped predictor size
    localparam int btb_entries = 16;

    // instruction memory depth in words
    localparam int mem_words = 256;

endpackage

// File: pc_gen.sv
`timescale 1ns/1ns

module pc_gen (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  redirect_wb,
    input  fetch_pkg::addr_t      redirect_wb_target,
    input  logic                  redirect_ex,
    input  fetch_pkg::addr_t      redirect_ex_target,
    input  logic                  fetch_allowin,
    input  logic                  pred_taken,
    input  fetch_pkg::addr_t      pred_target,
    output fetch_pkg::addr_t      fetch_pc,
    output logic                  fetch_fire,
    output fetch_pkg::slot_mask_t fetch_slot_mask,
    output logic                  flush
);
    import fetch_pkg::*;

    addr_t pc;
    addr_t aligned_pc;
    addr_t seq_pc;
    addr_t next_pc;

    // any redirect kills what is in flight
    assign flush = redirect_wb | redirect_ex;

    // no launch on the redirect edge, pc is being replaced
    assign fetch_fire = fetch_allowin & ~flush;

    assign fetch_pc = pc;

    // misaligned target: only the upper slot belongs to the stream
    assign fetch_slot_mask = pc[2] ? slot_mask_t'(2'b10) : slot_mask_t'(2'b11);

    // successor is always packet aligned, so a misaligned target is fetched once
    assign aligned_pc = pc & ~addr_t'(fetch_bytes - 1);
    assign seq_pc     = aligned_pc + addr_t'(fetch_bytes);

    // predicted taken wins over fall-through
    assign next_pc = pred_taken ? pred_target : seq_pc;

    // write-back beats execute, both beat the sequential step
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= pc_reset;
        end else if (redirect_wb) begin
            pc <= redirect_wb_target;
        end else if (redirect_ex) begin
            pc <= redirect_ex_target;
        end else if (fetch_fire) begin
            pc <= next_pc;
        end
    end

endmodule

// File: branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer (
    input  logic             clk,
    input  logic             rstn,
    input  fetch_pkg::addr_t lookup_pc,
    input  logic             upd_valid,
    input  fetch_pkg::addr_t upd_pc,
    input  fetch_pkg::addr_t upd_target,
    input  logic             upd_taken,
    output logic             pred_taken,
    output fetch_pkg::addr_t pred_target
);
    import fetch_pkg::*;

    // index starts just above the byte offset within a packet
    localparam int idx_lsb = $clog2(fetch_bytes);
    localparam int idx_w   = $bits(btb_idx_t);
    localparam int tag_w   = $bits(btb_tag_t);

    logic [btb_entries-1:0] entry_valid;
    btb_tag_t               entry_tag    [btb_entries];
    addr_t                  entry_target [btb_entries];

    btb_idx_t lookup_idx;
    btb_tag_t lookup_tag;
    btb_idx_t upd_idx;
    btb_tag_t upd_tag;
    logic     lookup_hit;
    logic     upd_hit;

    // split addresses into index and tag
    assign lookup_idx = lookup_pc[idx_lsb +: idx_w];
    assign lookup_tag = lookup_pc[31 -: tag_w];
    assign upd_idx    = upd_pc[idx_lsb +: idx_w];
    assign upd_tag    = upd_pc[31 -: tag_w];

    // lookup is purely combinational on the fetch pc
    assign lookup_hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);

    // only valid entries are ever written taken
    assign pred_taken  = lookup_hit;
    assign pred_target = entry_target[lookup_idx];

    // the update targets the same branch already held in the entry
    assign upd_hit = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);

    // valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            entry_valid <= '0;
        end else if (upd_valid) begin
            if (upd_taken) begin
                entry_valid[upd_idx] <= 1'b1;
            end else if (upd_hit) begin
                // resolved not taken, forget this branch
                entry_valid[upd_idx] <= 1'b0;
            end
        end
    end

    // tag and target storage, written on taken updates only
    always_ff @(posedge clk) begin
        if (upd_valid && upd_taken) begin
            entry_tag[upd_idx]    <= upd_tag;
            entry_target[upd_idx] <= upd_target;
        end
    end

endmodule

// File: inst_mem.sv
`timescale 1ns/1ns

module inst_mem (
    input  logic                 clk,
    input  logic                 read_en,
    input  fetch_pkg::addr_t     read_addr,
    input  logic                 load_en,
    input  fetch_pkg::mem_addr_t load_addr,
    input  fetch_pkg::inst_t     load_data,
    output fetch_pkg::inst_t     inst0,
    output fetch_pkg::inst_t     inst1
);
    import fetch_pkg::*;

    localparam int word_w = $bits(mem_addr_t);

    inst_t     mem [mem_words];
    mem_addr_t word_idx;
    mem_addr_t lower_idx;
    mem_addr_t upper_idx;

    // word index of the read address, byte offset dropped
    assign word_idx = read_addr[2 +: word_w];

    // both words of the aligned packet, whatever bit 2 says
    assign lower_idx = {word_idx[word_w-1:1], 1'b0};
    assign upper_idx = {word_idx[word_w-1:1], 1'b1};

    // load port, one word a cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read, output holds while no fetch is launched
    always_ff @(posedge clk) begin
        if (read_en) begin
            inst0 <= mem[lower_idx];
            inst1 <= mem[upper_idx];
        end
    end

endmodule

// File: fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic                  fetch_fire,
    input  fetch_pkg::addr_t      fetch_pc,
    input  fetch_pkg::slot_mask_t fetch_slot_mask,
    input  logic                  pred_taken,
    input  fetch_pkg::addr_t      pred_target,
    input  logic                  out_ready,
    output logic                  fetch_allowin,
    output logic                  out_valid,
    output fetch_pkg::addr_t      out_pc,
    output fetch_pkg::slot_mask_t out_slot_mask,
    output logic                  out_pred_taken,
    output fetch_pkg::addr_t      out_pred_target
);
    import fetch_pkg::*;

    logic       valid;
    logic       out_fire;
    addr_t      pc_q;
    slot_mask_t mask_q;
    logic       taken_q;
    addr_t      target_q;

    assign out_fire = valid & out_ready;

    // room when empty or the held packet leaves this cycle
    assign fetch_allowin = ~valid | out_fire;

    // occupancy, a redirect drops whatever is held
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (fetch_fire) begin
            valid <= 1'b1;
        end else if (out_fire) begin
            valid <= 1'b0;
        end
    end

    // packet side info, lines up with the memory output register
    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            pc_q     <= fetch_pc;
            mask_q   <= fetch_slot_mask;
            taken_q  <= pred_taken;
            target_q <= pred_target;
        end
    end

    assign out_valid       = valid;
    assign out_pc          = pc_q;
    assign out_slot_mask   = mask_q;
    assign out_pred_taken  = taken_q;
    assign out_pred_target = target_q;

endmodule

// File: fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  redirect_wb,
    input  fetch_pkg::addr_t      redirect_wb_target,
    input  logic                  redirect_ex,
    input  fetch_pkg::addr_t      redirect_ex_target,
    input  logic                  upd_valid,
    input  fetch_pkg::addr_t      upd_pc,
    input  fetch_pkg::addr_t      upd_target,
    input  logic                  upd_taken,
    input  logic                  load_en,
    input  fetch_pkg::mem_addr_t  load_addr,
    input  fetch_pkg::inst_t      load_data,
    input  logic                  out_ready,
    output logic                  out_valid,
    output fetch_pkg::addr_t      out_pc,
    output fetch_pkg::inst_t      out_inst0,
    output fetch_pkg::inst_t      out_inst1,
    output fetch_pkg::slot_mask_t out_slot_mask,
    output logic                  out_pred_taken,
    output fetch_pkg::addr_t      out_pred_target
);
    import fetch_pkg::*;

    addr_t      fetch_pc;
    logic       fetch_fire;
    logic       fetch_allowin;
    slot_mask_t fetch_slot_mask;
    logic       flush;
    logic       pred_taken;
    addr_t      pred_target;

    pc_gen u_pc_gen (
        .clk                (clk),
        .rstn               (rstn),
        .redirect_wb        (redirect_wb),
        .redirect_wb_target (redirect_wb_target),
        .redirect_ex        (redirect_ex),
        .redirect_ex_target (redirect_ex_target),
        .fetch_allowin      (fetch_allowin),
        .pred_taken         (pred_taken),
        .pred_target        (pred_target),
        .fetch_pc           (fetch_pc),
        .fetch_fire         (fetch_fire),
        .fetch_slot_mask    (fetch_slot_mask),
        .flush              (flush)
    );

    branch_target_buffer u_btb (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_pc   (fetch_pc),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_target  (upd_target),
        .upd_taken   (upd_taken),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    // memory output register is the instruction half of the second stage
    inst_mem u_inst_mem (
        .clk       (clk),
        .read_en   (fetch_fire),
        .read_addr (fetch_pc),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .inst0     (out_inst0),
        .inst1     (out_inst1)
    );

    fetch_buffer u_fetch_buffer (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .fetch_fire      (fetch_fire),
        .fetch_pc        (fetch_pc),
        .fetch_slot_mask (fetch_slot_mask),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .out_ready       (out_ready),
        .fetch_allowin   (fetch_allowin),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_slot_mask   (out_slot_mask),
        .out_pred_taken  (out_pred_taken),
        .out_pred_target (out_pred_target)
    );

endmodule

// File: fetch_props.sv
`timescale 1ns/1ns

module fetch_props (
    input logic             clk,
    input logic             rstn,
    input logic             redirect_wb,
    input logic             redirect_ex,
    input logic             out_ready,
    input logic             out_valid,
    input fetch_pkg::addr_t out_pc,
    input fetch_pkg::inst_t out_inst0,
    input fetch_pkg::inst_t out_inst1
);
    // a stalled packet stays put unless a redirect drops it
    assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready && !redirect_wb && !redirect_ex) |=>
            (out_valid && out_pc === $past(out_pc) && out_inst0 === $past(out_inst0)
             && out_inst1 === $past(out_inst1)))
        else $error("stalled packet changed before its transfer");

    assert property (@(posedge clk) disable iff (!rstn)
        (redirect_wb || redirect_ex) |=> !out_valid)
        else $error("packet still valid after a redirect");

    assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> (out_pc[1:0] == 2'b00))
        else $error("packet pc is not word aligned");

endmodule

bind fetch_top fetch_props u_props (
    .clk         (clk),
    .rstn        (rstn),
    .redirect_wb (redirect_wb),
    .redirect_ex (redirect_ex),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .out_inst0   (out_inst0),
    .out_inst1   (out_inst1)
);

// File: tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch;
    import fetch_pkg::*;

    localparam int wait_limit = 20;

    logic       clk, rstn, out_ready, out_valid, out_pred_taken;
    logic       redirect_wb, redirect_ex, upd_valid, upd_taken, load_en;
    addr_t      redirect_wb_target, redirect_ex_target, upd_pc, upd_target;
    addr_t      out_pc, out_pred_target;
    mem_addr_t  load_addr;
    inst_t      load_data, out_inst0, out_inst1;
    slot_mask_t out_slot_mask;

    // copy of the program image held in instruction memory
    inst_t  prog [mem_words];
    integer seed = 32'h64179a46;

    fetch_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_inst(inst_t got, inst_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_mask(slot_mask_t got, slot_mask_t exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // five cycles of reset, nothing may be held afterwards
    task automatic apply_reset();
        rstn = 1'b0;
        repeat (5) next_cycle();
        check_bit(out_valid, 1'b0, "out_valid in reset");
        rstn = 1'b1;
    endtask

    // wait for a packet, check it against the program copy, then take it
    task automatic expect_packet(addr_t pc, slot_mask_t mask, logic taken, addr_t target,
                                 string what);
        int waited = 0;
        int word = int'(pc[9:3]) * 2;
        out_ready = 1'b1;
        while (!out_valid) begin
            next_cycle();
            waited++;
            if (waited > wait_limit) begin
                stop_run({"packet ", what, " never arrived before the timeout"});
            end
        end
        check_addr(out_pc, pc, {what, " pc"});
        check_mask(out_slot_mask, mask, {what, " slot mask"});
        check_inst(out_inst0, prog[word], {what, " inst0"});
        check_inst(out_inst1, prog[word + 1], {what, " inst1"});
        check_bit(out_pred_taken, taken, {what, " prediction"});
        if (taken) check_addr(out_pred_target, target, {what, " predicted target"});
        next_cycle();
        out_ready = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_words; i++) begin
            prog[i] = $random(seed);
            load_en = 1'b1;
            load_addr = mem_addr_t'(i);
            load_data = prog[i];
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic redirect(logic wb, addr_t wb_target, logic ex, addr_t ex_target);
        redirect_wb = wb;
        redirect_wb_target = wb_target;
        redirect_ex = ex;
        redirect_ex_target = ex_target;
        next_cycle();
        {redirect_wb, redirect_ex} = 2'b00;
    endtask

    task automatic train(addr_t pc, addr_t target, logic taken);
        upd_valid = 1'b1;
        upd_pc = pc;
        upd_target = target;
        upd_taken = taken;
        next_cycle();
        upd_valid = 1'b0;
    endtask

    // memory keeps its contents through reset, so the stream starts at the reset pc
    task automatic test_sequential();
        apply_reset();
        for (int k = 0; k < 8; k++)
            expect_packet(pc_reset + addr_t'(fetch_bytes * k), 2'b11, 1'b0, '0, "sequential");
    endtask

    task automatic test_redirects();
        redirect(1'b0, '0, 1'b1, 32'h0000_0104);
        expect_packet(32'h0000_0104, 2'b10, 1'b0, '0, "misaligned target");
        expect_packet(32'h0000_0108, 2'b11, 1'b0, '0, "aligned successor");
        // write-back wins when both redirects share a cycle
        redirect(1'b1, 32'h0000_0200, 1'b1, 32'h0000_0300);
        expect_packet(32'h0000_0200, 2'b11, 1'b0, '0, "write-back target");
    endtask

    task automatic test_prediction();
        train(32'h0000_0240, 32'h0000_0380, 1'b1);
        redirect(1'b0, '0, 1'b1, 32'h0000_0230);
        expect_packet(32'h0000_0230, 2'b11, 1'b0, '0, "before branch");
        expect_packet(32'h0000_0238, 2'b11, 1'b0, '0, "before branch");
        expect_packet(32'h0000_0240, 2'b11, 1'b1, 32'h0000_0380, "predicted branch");
        expect_packet(32'h0000_0380, 2'b11, 1'b0, '0, "predicted target");
        train(32'h0000_0240, '0, 1'b0);
        redirect(1'b0, '0, 1'b1, 32'h0000_0238);
        expect_packet(32'h0000_0238, 2'b11, 1'b0, '0, "before cleared branch");
        expect_packet(32'h0000_0240, 2'b11, 1'b0, '0, "cleared branch");
        expect_packet(32'h0000_0248, 2'b11, 1'b0, '0, "fall-through");
    endtask

    task automatic test_backpressure();
        int stall;
        redirect(1'b0, '0, 1'b1, 32'h0000_0080);
        for (int k = 0; k < 12; k++) begin
            stall = $random(seed) & 7;
            repeat (stall) next_cycle();
            expect_packet(32'h0000_0080 + addr_t'(fetch_bytes * k), 2'b11, 1'b0, '0, "stalled");
        end
    endtask

    task automatic test_stall_redirect();
        repeat (3) next_cycle();
        check_bit(out_valid, 1'b1, "held packet valid");
        check_addr(out_pc, 32'h0000_00e0, "held packet pc");
        redirect(1'b0, '0, 1'b1, 32'h0000_0300);
        expect_packet(32'h0000_0300, 2'b11, 1'b0, '0, "target after stalled redirect");
    endtask

    initial begin
        {rstn, redirect_wb, redirect_ex, upd_valid, upd_taken, load_en, out_ready} = '0;
        {redirect_wb_target, redirect_ex_target, upd_pc, upd_target} = '0;
        {load_addr, load_data} = '0;
        apply_reset();
        load_program();
        test_sequential();
        test_redirects();
        test_prediction();
        test_backpressure();
        test_stall_redirect();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog.f
fetch_pkg.sv
pc_gen.sv
branch_target_buffer.sv
inst_mem.sv
fetch_buffer.sv
fetch_top.sv
fetch_props.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - pc_gen.sv
  - branch_target_buffer.sv
  - inst_mem.sv
  - fetch_buffer.sv
  - fetch_top.sv
  - target: simulation
    files:
      - fetch_props.sv
      - tb_fetch.sv
